// File: verif/uart_cases.txt
// One case per line, hex: mode byte stop read_between exp_data exp_ready exp_overrun exp_frame_err
// Mode 0 loopback, 1 direct frame on rx, 2 pair of the byte and its inverse back to back
00 55 1 0 55 1 0 0
00 a3 1 0 a3 1 0 0
00 00 1 0 00 1 0 0
00 ff 1 0 ff 1 0 0
01 3c 1 0 3c 1 0 0
01 81 0 0 81 1 0 1
01 7e 0 0 7e 1 0 1
02 12 1 0 ed 1 1 0
02 c4 1 1 3b 1 0 0
02 0f 1 1 f0 1 0 0
02 96 1 0 69 1 1 0
00 01 1 0 01 1 0 0
00 80 1 0 80 1 0 0
01 e7 1 0 e7 1 0 0
// End marker
ff ff ff ff ff ff ff ff

// File: filelist.f
design/uart_cfg_pkg.sv
design/uart_frame_pkg.sv
design/uart_tx_ctrl.sv
design/uart_tx_serializer.sv
design/uart_rx_sampler.sv
design/uart_rx_deserializer.sv
design/uart_rx_holding.sv
design/uart_top.sv
verif/uart_checker.sv
verif/uart_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= uart_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -Wno-fatal
PASS_MSG  ?= ALL CHECKS PASSED
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(wildcard design/*.sv verif/*.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; status=$$?; echo "$$out"; \
	[ $$status -eq 0 ] && echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: verif/uart_tb.sv
/* Testbench top: clock, reset, case-file reader, stimulus with loopback
   or direct rx routing, watchdog, the DUT and its checker */
`default_nettype none

module uart_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import uart_cfg_pkg::*;

    localparam int clks_per_bit = 16;
    localparam int clk_period = 40;
    localparam int drive_delay = 2;
    localparam int max_cases = 32;
    // Strobe selectors
    localparam int s_read = 0;
    localparam int s_result = 1;
    localparam int s_clear = 2;
    localparam int s_done = 3;

    logic       clk;
    logic       rst_n;
    uart_byte_t tx_data;
    logic       tx_valid;
    logic       tx_busy;
    logic       tx;
    logic       rx;
    logic       rx_drv;
    logic       loopback;
    uart_byte_t rx_data;
    logic       rx_ready, rx_overrun, rx_frame_err, rx_read;
    logic       check_result, check_clear, test_done;
    uart_byte_t exp_data;
    logic       exp_ready, exp_overrun, exp_frame_err;
    int         errors, tests, frames_sent, frames_seen;
    int         n_cases;
    int         tb_errors;
    logic [7:0] cases_mem [max_cases*8];
    logic [15:0] lfsr;

    // Serial input follows tx in loopback, else the testbench drives it
    assign rx = loopback ? tx : rx_drv;

    uart_top #(.clks_per_bit(clks_per_bit)) dut0 (.*);

    uart_checker #(.clks_per_bit(clks_per_bit)) checker0 (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic next_cycle();
        @(posedge clk);
        #drive_delay;
    endtask

    // 16-bit Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic random_bits(input int n, output int value);
        value = 0;
        repeat (n) begin
            lfsr = lfsr_next(lfsr);
            value = (value << 1) | int'(lfsr[0]);
        end
    endtask

    // One-cycle pulse on rx_read or on a checker request
    task automatic strobe(input int kind);
        {rx_read, check_result, check_clear, test_done} = 4'b1000 >> kind;
        next_cycle();
        {rx_read, check_result, check_clear, test_done} = 4'b0000;
    endtask

    task automatic send_byte(input uart_byte_t b);
        tx_data  = b;
        tx_valid = 1'b1;
        do next_cycle(); while (!tx_busy);
    endtask

    task automatic drive_frame(input uart_byte_t b, input logic stop);
        logic [frame_bits-1:0] bits;
        bits = {stop, b, 1'b0};
        for (int i = 0; i < frame_bits; i++) begin
            rx_drv = bits[i];
            repeat (clks_per_bit) next_cycle();
        end
        rx_drv = 1'b1;
    endtask

    task automatic wait_rise(input logic use_overrun, output logic seen);
        logic prev;
        logic cur;
        prev = use_overrun ? rx_overrun : rx_ready;
        seen = 1'b0;
        for (int i = 0; i < 3 * frame_bits * clks_per_bit && !seen; i++) begin
            next_cycle();
            cur  = use_overrun ? rx_overrun : rx_ready;
            seen = cur && !prev;
            prev = cur;
        end
        if (!seen) begin
            $display("%0t ns: %s never rose", $time, use_overrun ? "rx_overrun" : "rx_ready");
            tb_errors++;
        end
    endtask

    // Fields: mode, byte, stop, read between, expected data and three flags
    task automatic run_case(input int k);
        logic [7:0] f [8];
        logic       seen;
        int         base;
        for (int j = 0; j < 8; j++) begin
            f[j] = cases_mem[k*8 + j];
        end
        if (f[0] == 8'd1) begin
            loopback = 1'b0;
            fork
                drive_frame(f[1], f[2][0]);
                wait_rise(1'b0, seen);
            join
        end else begin
            loopback = 1'b1;
            base = frames_sent;
            send_byte(f[1]);
            if (f[0] == 8'd2) begin
                // tx_valid stays high, the inverse goes out back to back
                tx_data = ~f[1];
            end else begin
                tx_valid = 1'b0;
            end
            wait_rise(1'b0, seen);
            if (f[0] == 8'd2) begin
                if (f[3][0]) begin
                    exp_data = f[1];
                    {exp_ready, exp_overrun, exp_frame_err} = 3'b100;
                    strobe(s_result);
                    strobe(s_read);
                end
                while (frames_sent < base + 2) next_cycle();
                tx_valid = 1'b0;
                wait_rise(!f[3][0], seen);
            end
        end
        exp_data = f[4];
        {exp_ready, exp_overrun, exp_frame_err} = {f[5][0], f[6][0], f[7][0]};
        strobe(s_result);
        strobe(s_read);
        strobe(s_clear);
        while (tx_busy) next_cycle();
        strobe(s_done);
        loopback = 1'b1;
    endtask

    initial begin
        int gap;
        tx_data  = '0;
        tx_valid = 1'b0;
        rx_drv   = 1'b1;
        loopback = 1'b0;
        rx_read  = 1'b0;
        {check_result, check_clear, test_done} = 3'b000;
        exp_data = '0;
        {exp_ready, exp_overrun, exp_frame_err} = 3'b000;
        tb_errors = 0;
        lfsr  = 16'd65;
        rst_n = 1'b0;
        $readmemh("verif/uart_cases.txt", cases_mem);
        n_cases = 0;
        while (n_cases < max_cases && cases_mem[n_cases*8] <= 8'd2) n_cases++;
        if (n_cases == 0) begin
            $display("no test cases were read from verif/uart_cases.txt");
        end
        repeat (5) @(posedge clk);
        #drive_delay rst_n = 1'b1;
        // A low pulse well under half a bit must not start a frame
        next_cycle();
        rx_drv = 1'b0;
        repeat (4) next_cycle();
        rx_drv = 1'b1;
        repeat (2 * frame_bits * clks_per_bit) next_cycle();
        strobe(s_clear);
        strobe(s_done);
        loopback = 1'b1;
        for (int k = 0; k < n_cases; k++) begin
            random_bits(4, gap);
            repeat (gap + 2) next_cycle();
            run_case(k);
        end
        repeat (4) next_cycle();
        $display("tests %0d, errors %0d, frames requested %0d, frames decoded %0d",
                 tests, errors + tb_errors, frames_sent, frames_seen);
        if (n_cases > 0 && errors == 0 && tb_errors == 0 && frames_sent == frames_seen
            && tests == n_cases + 1) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // Time limit scales with the number of cases
    initial begin
        wait (n_cases > 0);
        #(n_cases * 3 * frame_bits * clks_per_bit * clk_period);
        $display("watchdog: the run did not finish in time, the DUT seems stuck");
        $display("CHECKS FAILED");
        $finish;
    end

endmodule : uart_tb

`default_nettype wire

// File: verif/uart_checker.sv
/* Testbench checker: decodes the tx line, times tx_busy and compares
   the receive outputs with the expected values of each test */
`default_nettype none

module uart_checker #(
    parameter int unsigned clks_per_bit = uart_cfg_pkg::default_clks_per_bit
) (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire uart_cfg_pkg::uart_byte_t tx_data,
    input  wire                           tx_valid,
    input  wire                           tx_busy,
    input  wire                           tx,
    input  wire uart_cfg_pkg::uart_byte_t rx_data,
    input  wire                           rx_ready,
    input  wire                           rx_overrun,
    input  wire                           rx_frame_err,
    input  wire                           check_result,
    input  wire                           check_clear,
    input  wire                           test_done,
    input  wire uart_cfg_pkg::uart_byte_t exp_data,
    input  wire                           exp_ready,
    input  wire                           exp_overrun,
    input  wire                           exp_frame_err,
    output int                            errors,
    output int                            tests,
    output int                            frames_sent,
    output int                            frames_seen
);
    timeunit 1ns;
    timeprecision 100ps;
    import uart_cfg_pkg::*;

    // Busy spans the whole frame plus the load cycle
    localparam int busy_cycles = frame_bits * clks_per_bit + 1;

    uart_byte_t sent_q[$];
    int         errors_mark;

    task automatic fail_text(input string msg);
        $display("%0t ns: %s", $time, msg);
        errors++;
    endtask

    task automatic compare(input string sig, input logic [31:0] got,
                           input logic [31:0] expected);
        if (got !== expected) begin
            $display("[FAIL] %0t ns %s got %0h expected %0h", $time, sig, got, expected);
            errors++;
        end
    endtask

    initial begin
        errors      = 0;
        tests       = 0;
        frames_sent = 0;
        frames_seen = 0;
        errors_mark = 0;
    end

    // Idle levels in the first cycle after reset
    initial begin
        @(posedge rst_n);
        @(posedge clk);
        compare("tx", tx, 1);
        compare("tx_busy", tx_busy, 0);
        compare("rx_ready", rx_ready, 0);
        compare("rx_overrun", rx_overrun, 0);
        compare("rx_frame_err", rx_frame_err, 0);
    end

    // Granted requests, start-bit timing and the width of each busy window
    initial begin
        int busy_len;
        forever begin
            @(posedge clk);
            while (rst_n && tx_valid && !tx_busy) begin
                sent_q.push_back(tx_data);
                frames_sent++;
                busy_len = 0;
                @(posedge clk);
                if (!tx_busy) begin
                    fail_text("tx_busy did not rise the cycle after the request");
                end
                compare("tx before start bit", tx, 1);
                while (tx_busy) begin
                    busy_len++;
                    if (busy_len == 2) begin
                        compare("tx start bit", tx, 0);
                    end
                    @(posedge clk);
                end
                compare("tx_busy cycles", busy_len, busy_cycles);
            end
        end
    end

    // Frame decoder for tx, each bit must hold for a full bit period
    initial begin
        logic                  tx_prev;
        logic [frame_bits-1:0] bits;
        int                    unstable;
        tx_prev = 1'b1;
        forever begin
            @(posedge clk);
            if (rst_n && tx_prev && !tx) begin
                unstable = 0;
                for (int i = 0; i < frame_bits; i++) begin
                    bits[i] = tx;
                    for (int c = 1; c < clks_per_bit; c++) begin
                        @(posedge clk);
                        if (tx !== bits[i]) begin
                            unstable++;
                        end
                    end
                    if (i < frame_bits - 1) begin
                        @(posedge clk);
                    end
                end
                frames_seen++;
                if (unstable != 0) begin
                    fail_text("tx changed inside a bit period");
                end
                compare("tx stop bit", bits[frame_bits-1], 1);
                if (sent_q.size() == 0) begin
                    fail_text("frame on tx without a granted request");
                end else begin
                    compare("tx data", bits[data_bits:1], sent_q.pop_front());
                end
            end
            tx_prev = tx;
        end
    end

    // Receive outputs on request, one report line per finished test
    initial begin
        forever begin
            @(posedge clk);
            if (check_result) begin
                compare("rx_data", rx_data, exp_data);
                compare("rx_ready", rx_ready, exp_ready);
                compare("rx_overrun", rx_overrun, exp_overrun);
                compare("rx_frame_err", rx_frame_err, exp_frame_err);
            end
            if (check_clear) begin
                compare("rx_ready", rx_ready, 0);
                compare("rx_overrun", rx_overrun, 0);
                compare("rx_frame_err", rx_frame_err, 0);
            end
            if (test_done) begin
                tests++;
                if (errors == errors_mark) begin
                    $display("test %0d: ok", tests);
                end else begin
                    $display("test %0d: failed with %0d errors", tests, errors - errors_mark);
                end
                errors_mark = errors;
            end
        end
    end

endmodule : uart_checker

`default_nettype wire

// File: design/uart_top.sv
/* UART top level: transmit and receive pipelines with the shared
   bit-period parameter */
`default_nettype none

module uart_top #(
    parameter int unsigned clks_per_bit = uart_cfg_pkg::default_clks_per_bit
) (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire uart_cfg_pkg::uart_byte_t tx_data,
    input  wire                       tx_valid,
    output logic                      tx_busy,
    output logic                      tx,
    input  wire                       rx,
    output uart_cfg_pkg::uart_byte_t  rx_data,
    output logic                      rx_ready,
    output logic                      rx_overrun,
    output logic                      rx_frame_err,
    input  wire                       rx_read
);
    import uart_frame_pkg::*;

    tx_load_t tx_load;
    logic     tx_done;
    rx_edge_t rx_edge;
    rx_word_t rx_word;

    // Transmit path
    uart_tx_ctrl u_tx_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .tx_done  (tx_done),
        .load     (tx_load),
        .tx_busy  (tx_busy)
    );

    uart_tx_serializer #(
        .clks_per_bit (clks_per_bit)
    ) u_tx_serializer (
        .clk     (clk),
        .rst_n   (rst_n),
        .load    (tx_load),
        .tx      (tx),
        .tx_done (tx_done)
    );

    // Receive path
    uart_rx_sampler u_rx_sampler (
        .clk      (clk),
        .rst_n    (rst_n),
        .rx       (rx),
        .edge_out (rx_edge)
    );

    uart_rx_deserializer #(
        .clks_per_bit (clks_per_bit)
    ) u_rx_deserializer (
        .clk     (clk),
        .rst_n   (rst_n),
        .edge_in (rx_edge),
        .word    (rx_word)
    );

    uart_rx_holding u_rx_holding (
        .clk          (clk),
        .rst_n        (rst_n),
        .word         (rx_word),
        .rx_read      (rx_read),
        .rx_data      (rx_data),
        .rx_ready     (rx_ready),
        .rx_overrun   (rx_overrun),
        .rx_frame_err (rx_frame_err)
    );

endmodule : uart_top

`default_nettype wire

// File: design/uart_rx_holding.sv
/* Receive holding register with new-data, overrun and framing flags,
   cleared by a host read pulse */
`default_nettype none

module uart_rx_holding (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire uart_frame_pkg::rx_word_t word,
    input  wire                       rx_read,
    output uart_cfg_pkg::uart_byte_t  rx_data,
    output logic                      rx_ready,
    output logic                      rx_overrun,
    output logic                      rx_frame_err
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_ready     <= 1'b0;
            rx_overrun   <= 1'b0;
            rx_frame_err <= 1'b0;
        end else if (word.done) begin
            // New byte wins over a read in the same cycle
            rx_ready     <= 1'b1;
            rx_overrun   <= rx_ready && !rx_read;
            rx_frame_err <= word.frame_err;
        end else if (rx_read) begin
            rx_ready     <= 1'b0;
            rx_overrun   <= 1'b0;
            rx_frame_err <= 1'b0;
        end
    end

    // Unread data is overwritten
    always_ff @(posedge clk) begin
        if (word.done) begin
            rx_data <= word.data;
        end
    end

    a_overrun_needs_ready: assert property (
        @(posedge clk) disable iff (!rst_n)
        rx_overrun |-> rx_ready
    );

endmodule : uart_rx_holding

`default_nettype wire

// File: design/uart_rx_deserializer.sv
/* Receive deserializer: start check at mid-bit, data sampling LSB first
   and stop-bit check, with glitch rejection */
`default_nettype none

module uart_rx_deserializer #(
    parameter int unsigned clks_per_bit = uart_cfg_pkg::default_clks_per_bit
) (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire uart_frame_pkg::rx_edge_t edge_in,
    output uart_frame_pkg::rx_word_t word
);
    import uart_cfg_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_data,
        st_stop
    } state_t;

    localparam int unsigned cnt_w = $clog2(clks_per_bit);
    localparam logic [cnt_w-1:0] cnt_last = cnt_w'(clks_per_bit - 1);
    localparam logic [cnt_w-1:0] half_last = cnt_w'(clks_per_bit / 2 - 1);
    localparam int unsigned bit_w = $clog2(data_bits);
    localparam logic [bit_w-1:0] bit_last = bit_w'(data_bits - 1);

    state_t           state;
    logic [cnt_w-1:0] cnt;
    logic [bit_w-1:0] bit_cnt;
    uart_byte_t       shift;
    logic             tick;
    logic             stop_sample;

    assign tick = (cnt == cnt_last);
    assign stop_sample = (state == st_stop) && tick;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= st_idle;
            cnt     <= '0;
            bit_cnt <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (edge_in.fall) begin
                        state <= st_start;
                        cnt   <= '0;
                    end
                end
                st_start: begin
                    // Half a bit later the start bit must still be low
                    if (cnt == half_last) begin
                        cnt     <= '0;
                        bit_cnt <= '0;
                        state   <= edge_in.line ? st_idle : st_data;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                st_data: begin
                    if (tick) begin
                        cnt     <= '0;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == bit_last) begin
                            state <= st_stop;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: begin
                    if (tick) begin
                        cnt   <= '0;
                        state <= st_idle;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // LSB arrives first and ends up at bit 0
    always_ff @(posedge clk) begin
        if (state == st_data && tick) begin
            shift <= {edge_in.line, shift[data_bits-1:1]};
        end
    end

    assign word = '{
        done:      stop_sample,
        data:      shift,
        frame_err: stop_sample && !edge_in.line
    };

    a_done_single_cycle: assert property (
        @(posedge clk) disable iff (!rst_n)
        word.done |=> !word.done
    );

endmodule : uart_rx_deserializer

`default_nettype wire

// File: design/uart_rx_sampler.sv
/* Receive input stage: synchronizer chain and falling-edge detect */
`default_nettype none

module uart_rx_sampler (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      rx,
    output uart_frame_pkg::rx_edge_t edge_out
);
    import uart_cfg_pkg::*;

    logic [sync_stages-1:0] sync_q;
    logic                   line_prev;
    logic                   line;

    assign line = sync_q[sync_stages-1];

    // Reset to the idle level so no false start is seen
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q    <= '1;
            line_prev <= 1'b1;
        end else begin
            sync_q    <= {sync_q[sync_stages-2:0], rx};
            line_prev <= line;
        end
    end

    assign edge_out = '{line: line, fall: line_prev && !line};

endmodule : uart_rx_sampler

`default_nettype wire

// File: design/uart_tx_serializer.sv
/* Transmit serializer: bit-period timer, bit index and shift register
   that put start, data LSB first and stop on the line */
`default_nettype none

module uart_tx_serializer #(
    parameter int unsigned clks_per_bit = uart_cfg_pkg::default_clks_per_bit
) (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire uart_frame_pkg::tx_load_t load,
    output logic                     tx,
    output logic                     tx_done
);
    import uart_cfg_pkg::*;

    localparam int unsigned cnt_w = $clog2(clks_per_bit);
    localparam logic [cnt_w-1:0] cnt_last = cnt_w'(clks_per_bit - 1);
    localparam int unsigned idx_w = $clog2(frame_bits);
    localparam logic [idx_w-1:0] idx_last = idx_w'(frame_bits - 1);

    logic                  active;
    logic [cnt_w-1:0]      cnt;
    logic [idx_w-1:0]      idx;
    logic [frame_bits-1:0] shift;
    logic                  bit_end;

    assign bit_end = active && (cnt == cnt_last);

    // Last cycle of the stop bit
    assign tx_done = bit_end && (idx == idx_last);

    // Line is driven straight from the register, idles high
    assign tx = shift[0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active <= 1'b0;
            cnt    <= '0;
            idx    <= '0;
            shift  <= '1;
        end else if (!active) begin
            if (load.start) begin
                active <= 1'b1;
                cnt    <= '0;
                idx    <= '0;
                shift  <= {1'b1, load.data, 1'b0};
            end
        end else if (bit_end) begin
            cnt   <= '0;
            // Ones shift in behind the frame, so the line returns to idle
            shift <= {1'b1, shift[frame_bits-1:1]};
            if (tx_done) begin
                active <= 1'b0;
                idx    <= '0;
            end else begin
                idx <= idx + 1'b1;
            end
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    a_idle_line_high: assert property (
        @(posedge clk) disable iff (!rst_n)
        !active |-> tx
    );

endmodule : uart_tx_serializer

`default_nettype wire

// File: design/uart_tx_ctrl.sv
/* Transmit controller: grants host requests while idle, latches the
   byte and keeps the busy flag until the serializer finishes */
`default_nettype none

module uart_tx_ctrl (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire uart_cfg_pkg::uart_byte_t tx_data,
    input  wire                       tx_valid,
    input  wire                       tx_done,
    output uart_frame_pkg::tx_load_t  load,
    output logic                      tx_busy
);
    import uart_cfg_pkg::*;

    uart_byte_t data_q;
    logic       start_q;
    logic       grant;

    // Requests seen while busy are simply ignored
    assign grant = tx_valid && !tx_busy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_busy <= 1'b0;
            start_q <= 1'b0;
        end else begin
            start_q <= grant;
            if (grant) begin
                tx_busy <= 1'b1;
            end else if (tx_done) begin
                tx_busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grant) begin
            data_q <= tx_data;
        end
    end

    assign load = '{start: start_q, data: data_q};

    // A load is only issued on the idle-to-busy transition
    a_load_only_from_idle: assert property (
        @(posedge clk) disable iff (!rst_n)
        load.start |-> tx_busy && $past(!tx_busy)
    );

endmodule : uart_tx_ctrl

`default_nettype wire

// File: design/uart_frame_pkg.sv
/* Stage-to-stage structs of the UART pipelines: tx load, rx edge
   information and the finished rx word */
`default_nettype none

package uart_frame_pkg;

    // Controller to serializer, start is a one-cycle strobe
    typedef struct packed {
        logic                   start;
        uart_cfg_pkg::uart_byte_t data;
    } tx_load_t;

    // Synchronized line level and its falling-edge strobe
    typedef struct packed {
        logic line;
        logic fall;
    } rx_edge_t;

    // One received frame, valid while done is high
    typedef struct packed {
        logic                   done;
        uart_cfg_pkg::uart_byte_t data;
        logic                   frame_err;
    } rx_word_t;

endpackage : uart_frame_pkg

`default_nettype wire

// File: design/uart_cfg_pkg.sv
/* Frame geometry constants, default bit period and the data byte type
   shared by the transmit and receive paths */
`default_nettype none

package uart_cfg_pkg;

    // 8N1 framing: start, data bits, one stop bit
    localparam int unsigned data_bits = 8;
    localparam int unsigned frame_bits = data_bits + 2;

    // Bit period in clk cycles, overridden from the top level
    localparam int unsigned default_clks_per_bit = 16;

    // Depth of the rx metastability chain
    localparam int unsigned sync_stages = 2;

    typedef logic [data_bits-1:0] uart_byte_t;

endpackage : uart_cfg_pkg

`default_nettype wire
